//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for a failure report

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module ff_drive_tb -f verilog.f -Mdir obj_dir -o ff_drive_sim
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "Verilator build failed with status $build_status"
   exit 1
fi

./obj_dir/ff_drive_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

grep -q "TESTBENCH FAILED" "$LOG"
grep_status=$?
if [ $grep_status -eq 0 ]; then
   echo "Failure reported in $LOG"
   exit 1
fi
if [ $grep_status -ne 1 ]; then
   echo "Could not search $LOG"
   exit 1
fi

echo "Simulation finished without reported failures"
exit 0

//--- tests/ff_clock_gen.sv
// Free-running 20 ns clock; rst_n held low for the first 10 cycles, released on a falling edge
`default_nettype none

module ff_clock_gen (
   output logic clk,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;  // Half period
   end

   initial begin
      rst_n = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);  // Away from the active edge
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

//--- tests/ff_drive_tb.sv
// Random setpoints stay within +/-100000 and slews within 500..8000; lengths leave a flat top
`default_nettype none

module ff_drive_tb
   import ff_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   logic                  clk;
   logic                  rst_n;
   logic                  cfg_valid;
   logic                  cfg_ready;
   logic [CFG_AW-1:0]     cfg_addr;
   logic [CFG_DW-1:0]     cfg_data;
   logic                  ext_trig;
   logic                  busy;
   logic signed [DWI-1:0] out_x;
   logic signed [DWI-1:0] out_y;

   // Reference copy of the register bank
   logic [LENGTH_WI-1:0]  exp_length;
   int                    exp_slew;
   logic signed [DWI-1:0] exp_setp_x;
   logic signed [DWI-1:0] exp_setp_y;

   int                    mismatches;
   int                    timeouts;
   string                 test_name;
   int                    busy_run;   // Busy cycles so far in this pulse
   int                    idle_cnt;   // Cycles since busy fell, saturates at 3
   logic                  flat_seen;
   logic                  busy_q;
   logic signed [DWI-1:0] out_x_q;
   logic signed [DWI-1:0] out_y_q;
   int                    rise_count;
   int                    fall_count;

   ff_clock_gen clock_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   ff_drive_top dut0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .cfg_valid (cfg_valid),
      .cfg_ready (cfg_ready),
      .cfg_addr  (cfg_addr),
      .cfg_data  (cfg_data),
      .ext_trig  (ext_trig),
      .busy      (busy),
      .out_x     (out_x),
      .out_y     (out_y)
   );

   function automatic int magnitude(input logic signed [DWI-1:0] v);
      return (v < 0) ? -int'(v) : int'(v);
   endfunction

   function automatic int step_size(input logic signed [DWI-1:0] a,
                                    input logic signed [DWI-1:0] b);
      int d;
      d = int'(a) - int'(b);
      return (d < 0) ? -d : d;
   endfunction

   // Pulse history seen by the checks below
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_q     <= 1'b0;
         busy_run   <= 0;
         idle_cnt   <= 3;
         flat_seen  <= 1'b0;
         out_x_q    <= '0;
         out_y_q    <= '0;
         rise_count <= 0;
         fall_count <= 0;
      end else begin
         busy_q   <= busy;
         out_x_q  <= out_x;
         out_y_q  <= out_y;
         busy_run <= busy ? busy_run + 1 : 0;
         if (busy) idle_cnt <= 0;
         else if (idle_cnt < 3) idle_cnt <= idle_cnt + 1;
         flat_seen <= busy && (flat_seen || (out_x == exp_setp_x && out_y == exp_setp_y));
         if (busy && !busy_q) rise_count <= rise_count + 1;
         if (!busy && busy_q) fall_count <= fall_count + 1;
      end
   end

   ready_lockout: assert property (@(posedge clk) disable iff (!rst_n)
      busy |-> !cfg_ready)
      else begin
         $display("mismatch %s: cfg_ready during pulse expected 0 actual 1", test_name);
         mismatches++;
      end

   slew_bound: assert property (@(posedge clk) disable iff (!rst_n)
      busy |-> step_size(out_x, out_x_q) <= exp_slew && step_size(out_y, out_y_q) <= exp_slew)
      else begin
         $display("mismatch %s: step expected at most %0d actual %0d/%0d", test_name, exp_slew,
                  step_size($sampled(out_x), $sampled(out_x_q)),
                  step_size($sampled(out_y), $sampled(out_y_q)));
         mismatches++;
      end

   sign_match: assert property (@(posedge clk) disable iff (!rst_n)
      busy |-> (out_x == 0 || out_x[DWI-1] == exp_setp_x[DWI-1])
            && (out_y == 0 || out_y[DWI-1] == exp_setp_y[DWI-1]))
      else begin
         $display("mismatch %s: sign expected as %0d/%0d actual %0d/%0d", test_name,
                  exp_setp_x, exp_setp_y, $sampled(out_x), $sampled(out_y));
         mismatches++;
      end

   level_bound: assert property (@(posedge clk) disable iff (!rst_n)
      busy |-> magnitude(out_x) <= magnitude(exp_setp_x)
            && magnitude(out_y) <= magnitude(exp_setp_y))
      else begin
         $display("mismatch %s: magnitude expected at most %0d/%0d actual %0d/%0d", test_name,
                  magnitude(exp_setp_x), magnitude(exp_setp_y),
                  magnitude($sampled(out_x)), magnitude($sampled(out_y)));
         mismatches++;
      end

   busy_length: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(busy) |-> busy_run == int'(exp_length) + PIPE_LAT + 1)
      else begin
         $display("mismatch %s: busy cycles expected %0d actual %0d", test_name,
                  int'(exp_length) + PIPE_LAT + 1, $sampled(busy_run));
         mismatches++;
      end

   flat_reached: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(busy) |-> flat_seen)
      else begin
         $display("mismatch %s: setpoints reached expected 1 actual 0", test_name);
         mismatches++;
      end

   // Third idle cycle onwards
   settle_zero: assert property (@(posedge clk) disable iff (!rst_n)
      (!busy && idle_cnt >= 2) |-> out_x == 0 && out_y == 0)
      else begin
         $display("mismatch %s: idle outputs expected 0/0 actual %0d/%0d", test_name,
                  $sampled(out_x), $sampled(out_y));
         mismatches++;
      end

   task automatic wait_busy(input logic level, input int max_cycles);
      int n;
      n = 0;
      while (busy !== level && n < max_cycles) begin
         @(negedge clk);
         n++;
      end
      if (busy !== level) begin
         $display("%s: busy did not reach %0d within %0d cycles", test_name, level, max_cycles);
         timeouts++;
      end
   endtask

   task automatic write_reg(input logic [CFG_AW-1:0] addr, input logic [CFG_DW-1:0] data,
                            input int max_cycles);
      int n;
      @(negedge clk);
      cfg_valid = 1'b1;
      cfg_addr  = addr;
      cfg_data  = data;
      n = 0;
      while (!cfg_ready && n < max_cycles) begin
         @(negedge clk);
         n++;
      end
      if (!cfg_ready) begin
         $display("%s: write to address %0d never accepted", test_name, addr);
         timeouts++;
         cfg_valid = 1'b0;
      end else begin
         @(negedge clk);  // Handshake on the rising edge in between
         cfg_valid = 1'b0;
         case (addr)
            ADDR_LENGTH: exp_length = data[LENGTH_WI-1:0];
            ADDR_SLEW:   exp_slew   = int'(data[DWI-2:0]);
            ADDR_SETP_X: exp_setp_x = data[DWI-1:0];
            ADDR_SETP_Y: exp_setp_y = data[DWI-1:0];
            default: ;
         endcase
      end
   endtask

   task automatic run_sw_pulse(input int index);
      int                    mag_x;
      int                    mag_y;
      int                    slew;
      int                    rise;
      int                    len;
      int                    falls;
      logic signed [DWI-1:0] sx;
      logic signed [DWI-1:0] sy;
      test_name = $sformatf("sw_pulse_%0d", index);
      mag_x = $urandom_range(100000, 0);
      mag_y = (index == 1) ? 0 : $urandom_range(100000, 0);
      slew  = $urandom_range(8000, 500);
      sx = $urandom_range(1, 0) ? DWI'(-mag_x) : DWI'(mag_x);
      sy = $urandom_range(1, 0) ? DWI'(-mag_y) : DWI'(mag_y);
      rise = ((mag_x > mag_y ? mag_x : mag_y) + slew - 1) / slew;
      len  = 2 * rise + 10 + $urandom_range(20, 0);
      write_reg(ADDR_LENGTH, CFG_DW'(len), 20);
      write_reg(ADDR_SLEW, CFG_DW'(slew), 20);
      write_reg(ADDR_SETP_X, CFG_DW'(sx), 20);
      write_reg(ADDR_SETP_Y, CFG_DW'(sy), 20);
      write_reg(ADDR_SW_TRIG, '0, 20);
      wait_busy(1'b1, 10);
      if (index == 0) begin
         // Held off until the pulse is over
         falls = fall_count;
         write_reg(ADDR_TRIG_MODE, CFG_DW'(TRIG_SW), len + 20);
         assert (fall_count > falls) else begin
            $display("mismatch %s: write after pulse end expected 1 actual 0", test_name);
            mismatches++;
         end
      end
      wait_busy(1'b0, len + 20);
      repeat (5) @(negedge clk);
   endtask

   initial begin
      int n;
      int rises;
      void'($urandom(32'hd668c3ca));
      cfg_valid  = 1'b0;
      cfg_addr   = '0;
      cfg_data   = '0;
      ext_trig   = 1'b0;
      mismatches = 0;
      timeouts   = 0;
      test_name  = "reset";
      exp_length = LENGTH_WI'(64);  // Register bank reset values
      exp_slew   = 1;
      exp_setp_x = '0;
      exp_setp_y = '0;

      n = 0;
      while (!cfg_ready && n < 40) begin
         @(negedge clk);
         n++;
      end
      if (!cfg_ready) begin
         $display("reset: cfg_ready never went high");
         timeouts++;
      end
      assert (!busy && out_x == 0 && out_y == 0) else begin
         $display("mismatch reset: busy/out_x/out_y expected 0/0/0 actual %0d/%0d/%0d",
                  busy, out_x, out_y);
         mismatches++;
      end

      for (int i = 0; i < 4; i++) begin
         run_sw_pulse(i);
      end

      // Second external edge inside a running pulse
      test_name = "ext_retrigger";
      write_reg(ADDR_TRIG_MODE, CFG_DW'(TRIG_EXT), 20);
      rises = rise_count;
      ext_trig = 1'b1;
      wait_busy(1'b1, 10);
      repeat (2) @(negedge clk);
      ext_trig = 1'b0;
      repeat (3) @(negedge clk);
      ext_trig = 1'b1;
      wait_busy(1'b0, int'(exp_length) + 20);
      repeat (10) @(negedge clk);
      assert (rise_count == rises + 1) else begin
         $display("mismatch %s: pulses expected %0d actual %0d", test_name, rises + 1,
                  rise_count);
         mismatches++;
      end
      ext_trig = 1'b0;

      test_name = "ext_ignored";
      write_reg(ADDR_TRIG_MODE, CFG_DW'(TRIG_SW), 20);
      repeat (5) @(negedge clk);
      rises = rise_count;
      ext_trig = 1'b1;
      repeat (10) @(negedge clk);
      assert (rise_count == rises && !busy) else begin
         $display("mismatch %s: pulses expected %0d actual %0d", test_name, rises, rise_count);
         mismatches++;
      end
      ext_trig = 1'b0;
      repeat (5) @(negedge clk);

      $display("checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
      if (mismatches == 0 && timeouts == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
verilog/ff_pkg.sv
verilog/reg_delay.sv
verilog/ff_settings.sv
verilog/ff_trigger.sv
verilog/ff_pulser.sv
verilog/ff_drive_top.sv
tests/ff_clock_gen.sv
tests/ff_drive_tb.sv

//--- verilog/ff_drive_top.sv
// Single RF channel drive; no readback and no DAC interface, outputs are raw signed samples
`default_nettype none

module ff_drive_top
   import ff_pkg::*;
(
   input  wire                   clk,
   input  wire                   rst_n,
   input  wire                   cfg_valid,
   output logic                  cfg_ready,
   input  wire  [CFG_AW-1:0]     cfg_addr,
   input  wire  [CFG_DW-1:0]     cfg_data,
   input  wire                   ext_trig,
   output logic                  busy,
   output logic signed [DWI-1:0] out_x,
   output logic signed [DWI-1:0] out_y
);

   logic [LENGTH_WI-1:0]  length;
   logic [DWI-2:0]        slew_limit;
   logic signed [DWI-1:0] setp_x;
   logic signed [DWI-1:0] setp_y;
   logic                  trig_mode;
   logic                  sw_trig;
   logic                  start;

   ff_settings settings (
      .clk        (clk),
      .rst_n      (rst_n),
      .cfg_valid  (cfg_valid),
      .cfg_ready  (cfg_ready),
      .cfg_addr   (cfg_addr),
      .cfg_data   (cfg_data),
      .busy       (busy),        // Write lockout
      .length     (length),
      .slew_limit (slew_limit),
      .setp_x     (setp_x),
      .setp_y     (setp_y),
      .trig_mode  (trig_mode),
      .sw_trig    (sw_trig)
   );

   ff_trigger trigger (
      .clk       (clk),
      .rst_n     (rst_n),
      .ext_trig  (ext_trig),
      .sw_trig   (sw_trig),
      .trig_mode (trig_mode),
      .start     (start)
   );

   ff_pulser pulser (
      .clk        (clk),
      .rst_n      (rst_n),
      .start      (start),
      .length     (length),
      .slew_limit (slew_limit),
      .setp_x     (setp_x),
      .setp_y     (setp_y),
      .busy       (busy),
      .out_x      (out_x),
      .out_y      (out_y)
   );

endmodule

`default_nettype wire

//--- verilog/ff_pkg.sv
// Shared widths, register map and trigger codes; CFG_DW must cover the widest register field
`default_nettype none

package ff_pkg;

   // Field widths
   localparam int LENGTH_WI = 20;  // Pulse length and internal counters
   localparam int DWI       = 18;  // Signed setpoint and output sample
   localparam int CFG_AW    = 3;
   localparam int CFG_DW    = 20;  // Length is the widest field

   // Register map, one field per address
   localparam logic [CFG_AW-1:0] ADDR_LENGTH    = CFG_AW'(0);
   localparam logic [CFG_AW-1:0] ADDR_SLEW      = CFG_AW'(1);
   localparam logic [CFG_AW-1:0] ADDR_SETP_X    = CFG_AW'(2);
   localparam logic [CFG_AW-1:0] ADDR_SETP_Y    = CFG_AW'(3);
   localparam logic [CFG_AW-1:0] ADDR_TRIG_MODE = CFG_AW'(4);
   localparam logic [CFG_AW-1:0] ADDR_SW_TRIG   = CFG_AW'(5);  // Write only, data ignored

   // Trigger source select
   localparam logic TRIG_SW  = 1'b0;  // Software strobe only
   localparam logic TRIG_EXT = 1'b1;  // External rising edge only

   // Cycles from accepted start until the length counter runs
   localparam int PIPE_LAT = 3;

endpackage

`default_nettype wire

//--- verilog/ff_pulser.sv
// Settings must hold during a pulse; slew nonzero, setpoints above the most negative code
`default_nettype none

module ff_pulser
   import ff_pkg::*;
(
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire                    start,       // Ignored while a pulse runs
   input  wire  [LENGTH_WI-1:0]   length,      // Total length incl. rise and fall
   input  wire  [DWI-2:0]         slew_limit,  // Max step per cycle
   input  wire  signed [DWI-1:0]  setp_x,
   input  wire  signed [DWI-1:0]  setp_y,
   output logic                   busy,
   output logic signed [DWI-1:0]  out_x,
   output logic signed [DWI-1:0]  out_y
);

   logic                 start_g;
   logic                 start_dly;
   logic                 run;        // Length counter active
   logic                 pulse_end;
   logic [LENGTH_WI-1:0] len_cnt;
   logic [LENGTH_WI-1:0] rise_cnt;
   logic [LENGTH_WI-1:0] fall_t;     // Count at which the ramp-down begins
   logic                 fall;
   logic                 x_pos;
   logic                 y_pos;
   logic [DWI-2:0]       setp_x_mag;
   logic [DWI-2:0]       setp_y_mag;
   logic [DWI-1:0]       slew_w;
   logic [DWI-1:0]       setp_x_w;
   logic [DWI-1:0]       setp_y_w;
   logic [DWI-1:0]       x_next;     // Ramp accumulators, never negative
   logic [DWI-1:0]       y_next;
   logic                 x_hit;
   logic                 y_hit;
   logic [DWI-2:0]       x_mag;
   logic [DWI-2:0]       y_mag;
   logic                 x_railed;
   logic                 y_railed;
   logic                 x_railed_r;
   logic                 y_railed_r;
   logic [DWI-1:0]       out_x_abs;
   logic [DWI-1:0]       out_y_abs;
   logic [DWI-1:0]       setp_x_abs;
   logic [DWI-1:0]       setp_y_abs;

   assign start_g   = start && !busy;
   assign pulse_end = run && (len_cnt == length);

   // Start marker aligned with the ramp pipeline
   reg_delay #(
      .dw  (1),
      .len (PIPE_LAT)
   ) pipe_lat (
      .clk   (clk),
      .rst_n (rst_n),
      .gate  (1'b1),
      .clear (pulse_end),
      .din   (start_g),
      .dout  (start_dly)
   );

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy     <= 1'b0;
         run      <= 1'b0;
         len_cnt  <= '0;
         rise_cnt <= '0;
         fall_t   <= '0;
         fall     <= 1'b0;
      end else begin
         if (start_g) begin
            busy     <= 1'b1;
            len_cnt  <= '0;
            rise_cnt <= '0;
            fall_t   <= '0;
            fall     <= 1'b0;
         end
         if (start_dly) run <= 1'b1;
         if (run) begin
            len_cnt <= len_cnt + 1'b1;
            if (pulse_end) begin  // Hard stop at the programmed length
               busy <= 1'b0;
               run  <= 1'b0;
            end
            if ((fall_t != '0) && (len_cnt == fall_t)) fall <= 1'b1;
            // Mirror the rise time at the end of the pulse
            if (x_railed_r && y_railed_r) begin
               fall_t <= length - rise_cnt - LENGTH_WI'(PIPE_LAT + 2);
            end else begin
               rise_cnt <= rise_cnt + 1'b1;
            end
         end
      end
   end

   assign x_pos = !setp_x[DWI-1];
   assign y_pos = !setp_y[DWI-1];

   always_ff @(posedge clk) begin
      setp_x_mag <= x_pos ? setp_x[DWI-2:0] : ~setp_x[DWI-2:0] + 1'b1;
      setp_y_mag <= y_pos ? setp_y[DWI-2:0] : ~setp_y[DWI-2:0] + 1'b1;
   end

   assign slew_w   = {1'b0, slew_limit};
   assign setp_x_w = {1'b0, setp_x_mag};
   assign setp_y_w = {1'b0, setp_y_mag};
   assign x_hit    = x_next >= setp_x_w;
   assign y_hit    = y_next >= setp_y_w;

   // Ramp accumulators step by the slew limit until railed
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         x_next <= '0;
         y_next <= '0;
      end else if (busy) begin
         if (x_railed) x_next <= setp_x_w;
         else if (fall) x_next <= (x_next >= slew_w) ? x_next - slew_w : '0;
         else x_next <= x_next + slew_w;
         if (y_railed) y_next <= setp_y_w;
         else if (fall) y_next <= (y_next >= slew_w) ? y_next - slew_w : '0;
         else y_next <= y_next + slew_w;
      end else begin
         x_next <= '0;
         y_next <= '0;
      end
   end

   // Clamp at the setpoint on the way up
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         x_railed   <= 1'b0;
         y_railed   <= 1'b0;
         x_railed_r <= 1'b0;
         y_railed_r <= 1'b0;
         x_mag      <= '0;
         y_mag      <= '0;
      end else if (busy) begin
         x_railed_r <= x_railed;  // Aligned with the length counter
         y_railed_r <= y_railed;
         if (!fall) begin
            x_railed <= x_hit;
            y_railed <= y_hit;
            x_mag    <= x_hit ? setp_x_mag : x_next[DWI-2:0];
            y_mag    <= y_hit ? setp_y_mag : y_next[DWI-2:0];
         end else begin
            x_railed <= 1'b0;
            y_railed <= 1'b0;
            x_mag    <= x_next[DWI-2:0];
            y_mag    <= y_next[DWI-2:0];
         end
      end else begin
         x_railed   <= 1'b0;
         y_railed   <= 1'b0;
         x_railed_r <= 1'b0;
         y_railed_r <= 1'b0;
         x_mag      <= '0;
         y_mag      <= '0;
      end
   end

   // Restore signs
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_x <= '0;
         out_y <= '0;
      end else begin
         out_x <= x_pos ? $signed({1'b0, x_mag}) : -$signed({1'b0, x_mag});
         out_y <= y_pos ? $signed({1'b0, y_mag}) : -$signed({1'b0, y_mag});
      end
   end

   assign out_x_abs  = out_x[DWI-1] ? -out_x : out_x;
   assign out_y_abs  = out_y[DWI-1] ? -out_y : out_y;
   assign setp_x_abs = setp_x[DWI-1] ? -setp_x : setp_x;
   assign setp_y_abs = setp_y[DWI-1] ? -setp_y : setp_y;

   out_bounded: assert property (@(posedge clk) disable iff (!rst_n)
      busy |-> (out_x_abs <= setp_x_abs) && (out_y_abs <= setp_y_abs))
      else $error("ff_pulser: output magnitude above setpoint");

   busy_needs_start: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(busy) |-> $past(start))
      else $error("ff_pulser: busy rose without a start");

endmodule

`default_nettype wire

//--- verilog/ff_settings.sv
// Write-only register bank; writes to unused addresses are dropped, fields take the low data bits
`default_nettype none

module ff_settings
   import ff_pkg::*;
(
   input  wire                   clk,
   input  wire                   rst_n,
   input  wire                   cfg_valid,
   output logic                  cfg_ready,
   input  wire  [CFG_AW-1:0]     cfg_addr,
   input  wire  [CFG_DW-1:0]     cfg_data,
   input  wire                   busy,        // Pulse in progress
   output logic [LENGTH_WI-1:0]  length,
   output logic [DWI-2:0]        slew_limit,
   output logic signed [DWI-1:0] setp_x,
   output logic signed [DWI-1:0] setp_y,
   output logic                  trig_mode,
   output logic                  sw_trig
);

   logic ready_en;  // Set once reset is released
   logic wr_en;

   // Settings stay frozen for the whole pulse
   assign cfg_ready = ready_en && !busy;
   assign wr_en     = cfg_valid && cfg_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ready_en <= 1'b0;
      end else begin
         ready_en <= 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         length     <= LENGTH_WI'(64);
         slew_limit <= (DWI-1)'(1);
         setp_x     <= '0;
         setp_y     <= '0;
         trig_mode  <= TRIG_SW;
      end else if (wr_en) begin
         case (cfg_addr)
            ADDR_LENGTH:    length     <= cfg_data[LENGTH_WI-1:0];
            ADDR_SLEW:      slew_limit <= cfg_data[DWI-2:0];
            ADDR_SETP_X:    setp_x     <= cfg_data[DWI-1:0];
            ADDR_SETP_Y:    setp_y     <= cfg_data[DWI-1:0];
            ADDR_TRIG_MODE: trig_mode  <= cfg_data[0];
            default: ;  // Software trigger and unused addresses
         endcase
      end
   end

   // One-cycle strobe per software trigger write
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sw_trig <= 1'b0;
      end else begin
         // Back-to-back writes give no second strobe
         sw_trig <= wr_en && (cfg_addr == ADDR_SW_TRIG) && !sw_trig;
      end
   end

endmodule

`default_nettype wire

//--- verilog/ff_trigger.sv
// ext_trig may be asynchronous; only its rising edge counts, and trig_mode picks one source
`default_nettype none

module ff_trigger
   import ff_pkg::*;
(
   input  wire  clk,
   input  wire  rst_n,
   input  wire  ext_trig,   // Asynchronous external trigger
   input  wire  sw_trig,    // Strobe from the register bank
   input  wire  trig_mode,
   output logic start       // One-cycle start request
);

   logic ext_s1;
   logic ext_s2;
   logic ext_s3;    // Previous synchronized level
   logic ext_rise;

   // Two-flop synchronizer plus history for edge detect
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ext_s1 <= 1'b0;
         ext_s2 <= 1'b0;
         ext_s3 <= 1'b0;
      end else begin
         ext_s1 <= ext_trig;
         ext_s2 <= ext_s1;
         ext_s3 <= ext_s2;
      end
   end

   assign ext_rise = ext_s2 && !ext_s3;

   // Registered source select
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         start <= 1'b0;
      end else if (trig_mode == TRIG_EXT) begin
         start <= ext_rise;
      end else begin
         start <= sw_trig;  // External edges ignored in software mode
      end
   end

   start_single: assert property (@(posedge clk) disable iff (!rst_n)
      start |=> !start)
      else $error("ff_trigger: start held for two cycles");

endmodule

`default_nettype wire

//--- verilog/reg_delay.sv
// Generic delay line of len stages; clear takes priority over gate, and len must be at least 1
`default_nettype none

module reg_delay #(
   parameter int dw  = 1,
   parameter int len = 1
) (
   input  wire           clk,
   input  wire           rst_n,
   input  wire           gate,   // Shift enable
   input  wire           clear,  // Zeroes every stage
   input  wire  [dw-1:0] din,
   output logic [dw-1:0] dout
);

   logic [dw-1:0] stage [len];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < len; i++) begin
            stage[i] <= '0;
         end
      end else if (clear) begin
         for (int i = 0; i < len; i++) begin
            stage[i] <= '0;
         end
      end else if (gate) begin
         stage[0] <= din;
         for (int i = 1; i < len; i++) begin
            stage[i] <= stage[i-1];  // Oldest sample ends up at the top
         end
      end
   end

   assign dout = stage[len-1];

   len_min: assert property (@(posedge clk) len >= 1)
      else $error("reg_delay: len must be at least 1");

endmodule

`default_nettype wire
